// ==== Makefile ====
TOP = plat_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f plat_top.f

# assertion errors must not stop the run before the testbench reports
run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	grep -qx "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== plat_top.f ====
+incdir+src
src/plat_pkg.sv
src/mmio_decoder.sv
src/mtimer.sv
src/plic_core.sv
src/plat_top.sv
sim/plat_checker.sv
sim/plat_tb.sv

// ==== sim/plat_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "plat_consts.svh"

module plat_checker
    import plat_pkg::*;
(
    input logic       clk,
    input logic       rst_i,
    input logic       s_awvalid_i,
    input logic       s_wvalid_i,
    input logic       s_awready_o,
    input logic       s_wready_o,
    input logic       s_bvalid_o,
    input logic [1:0] s_bresp_o,
    input logic       s_bready_i,
    input logic       s_arvalid_i,
    input logic       s_arready_o,
    input logic       s_rvalid_o,
    input word_t      s_rdata_o,
    input logic [1:0] s_rresp_o,
    input logic       s_rready_i,
    input word_t      irq_o
);

    int unsigned err_cnt = 0;
    logic        wr_acc, rd_acc;
    word_t       irq_mask;

    assign wr_acc   = s_awvalid_i & s_wvalid_i & s_awready_o & s_wready_o;
    assign rd_acc   = s_arvalid_i & s_arready_o;
    assign irq_mask = (32'd1 << `PLAT_MTI_BIT) | (32'd1 << `PLAT_MEI_BIT);

    ////////////////////
    // reset and handshake
    ////////////////////

    a_reset_state: assert property (@(posedge clk)
        rst_i |=> !s_bvalid_o && !s_rvalid_o
                  && s_awready_o && s_wready_o && s_arready_o && irq_o == '0)
    else begin
        $error("bus or irq not idle after reset");
        err_cnt = err_cnt + 1;
    end

    a_b_after_accept: assert property (@(posedge clk) disable iff (rst_i)
        wr_acc |=> s_bvalid_o && !$past(s_bvalid_o))
    else begin
        $error("bvalid did not rise one cycle after the write accept");
        err_cnt = err_cnt + 1;
    end

    a_r_after_accept: assert property (@(posedge clk) disable iff (rst_i)
        rd_acc |=> s_rvalid_o && !$past(s_rvalid_o))
    else begin
        $error("rvalid did not rise one cycle after the read accept");
        err_cnt = err_cnt + 1;
    end

    // held responses keep their payload
    a_b_hold: assert property (@(posedge clk) disable iff (rst_i)
        s_bvalid_o && !s_bready_i |=> s_bvalid_o && $stable(s_bresp_o))
    else begin
        $error("write response dropped or changed under back-pressure");
        err_cnt = err_cnt + 1;
    end

    a_r_hold: assert property (@(posedge clk) disable iff (rst_i)
        s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o) && $stable(s_rresp_o))
    else begin
        $error("read response dropped or changed under back-pressure");
        err_cnt = err_cnt + 1;
    end

    a_no_accept_busy: assert property (@(posedge clk) disable iff (rst_i)
        (s_bvalid_o || s_rvalid_o) |-> !s_awready_o && !s_wready_o && !s_arready_o)
    else begin
        $error("address ready high while a response is pending");
        err_cnt = err_cnt + 1;
    end

    a_irq_layout: assert property (@(posedge clk) disable iff (rst_i)
        (irq_o & ~irq_mask) == '0)  // only mti and meip may be set
    else begin
        $error("irq vector has bits outside mti and meip");
        err_cnt = err_cnt + 1;
    end

endmodule

bind plat_top plat_checker i_chk (.*);

`default_nettype wire

// ==== sim/plat_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "plat_consts.svh"

module plat_tb
    import plat_pkg::*;
();

    localparam int         TMO    = 100;  // cycles per wait
    localparam logic [1:0] OKAY   = 2'b00;
    localparam logic [1:0] SLVERR = 2'b10;

    logic        clk;
    logic        rst_i;
    logic        s_awvalid_i, s_wvalid_i, s_bready_i, s_arvalid_i, s_rready_i;
    word_t       s_awaddr_i, s_wdata_i, s_araddr_i;
    strb_t       s_wstrb_i;
    logic        s_awready_o, s_wready_o, s_bvalid_o, s_arready_o, s_rvalid_o;
    logic [1:0]  s_bresp_o, s_rresp_o;
    word_t       s_rdata_o;
    src_mask_t   irq_src_i;
    word_t       irq_o;

    plat_top i_dut (.*);

    always #4 clk = ~clk;

    function automatic word_t reg_addr(input logic [3:0] region, input logic [3:0] off);
        return {region, 24'h0, off};
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1, "simulation stopped");
    endtask

    // bound checker keeps a failure count
    always @(negedge clk) begin
        if (i_dut.i_chk.err_cnt != 0) begin
            abort_run("an assertion in the bound checker failed");
        end
    end

    ////////////////////
    // axi4-lite master
    ////////////////////

    task automatic axil_write(input word_t addr, input word_t data, output logic [1:0] resp);
        int n;
        int d;
        @(posedge clk);
        s_awvalid_i <= 1'b1;
        s_awaddr_i  <= addr;
        s_wvalid_i  <= 1'b1;
        s_wdata_i   <= data;
        s_wstrb_i   <= 4'hF;
        n = 0;
        @(negedge clk);
        while (!(s_awready_o && s_wready_o)) begin
            n++;
            if (n > TMO) abort_run("timeout waiting for awready and wready");
            @(negedge clk);
        end
        @(posedge clk);  // accept edge
        s_awvalid_i <= 1'b0;
        s_wvalid_i  <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!s_bvalid_o) begin
            n++;
            if (n > TMO) abort_run("timeout waiting for bvalid");
            @(negedge clk);
        end
        d = $urandom_range(3, 0);  // bready back-pressure
        repeat (d + 1) @(posedge clk);
        s_bready_i <= 1'b1;
        @(negedge clk);
        resp = s_bresp_o;
        @(posedge clk);
        s_bready_i <= 1'b0;
    endtask

    task automatic axil_read(input word_t addr, output word_t data, output logic [1:0] resp);
        int n;
        int d;
        @(posedge clk);
        s_arvalid_i <= 1'b1;
        s_araddr_i  <= addr;
        n = 0;
        @(negedge clk);
        while (!s_arready_o) begin
            n++;
            if (n > TMO) abort_run("timeout waiting for arready");
            @(negedge clk);
        end
        @(posedge clk);
        s_arvalid_i <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!s_rvalid_o) begin
            n++;
            if (n > TMO) abort_run("timeout waiting for rvalid");
            @(negedge clk);
        end
        d = $urandom_range(3, 0);
        repeat (d + 1) @(posedge clk);
        s_rready_i <= 1'b1;
        @(negedge clk);
        data = s_rdata_o;
        resp = s_rresp_o;
        @(posedge clk);
        s_rready_i <= 1'b0;
    endtask

    task automatic write_check(input word_t addr, input word_t data, input logic [1:0] exp_resp);
        logic [1:0] resp;
        axil_write(addr, data, resp);
        assert (resp == exp_resp) else
            abort_run($sformatf("FAILED at %0d ns: write %h bresp %0d, expected %0d",
                                $time, addr, resp, exp_resp));
    endtask

    task automatic read_check(input word_t addr, input word_t exp, input logic [1:0] exp_resp);
        word_t      data;
        logic [1:0] resp;
        axil_read(addr, data, resp);
        assert (data == exp && resp == exp_resp) else
            abort_run($sformatf("FAILED at %0d ns: read %h gave %h resp %0d, expected %h resp %0d",
                                $time, addr, data, resp, exp, exp_resp));
    endtask

    task automatic wait_irq(input int bit_idx, input logic level, input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (irq_o[bit_idx] !== level) begin
            n++;
            if (n > limit) abort_run($sformatf("timeout waiting for irq_o[%0d] to reach %b",
                                               bit_idx, level));
            @(negedge clk);
        end
    endtask

    task automatic irq_check(input int bit_idx, input logic exp);
        assert (irq_o[bit_idx] == exp) else
            abort_run($sformatf("FAILED at %0d ns: irq_o[%0d] is %b, expected %b",
                                $time, bit_idx, irq_o[bit_idx], exp));
    endtask

    ////////////////////
    // test sequence
    ////////////////////

    initial begin
        word_t      t0, t1;
        word_t      cmp_off;
        logic [1:0] resp;
        void'($urandom(32'hf9cc));
        clk         = 1'b0;
        rst_i       = 1'b1;
        s_awvalid_i = 1'b0;
        s_awaddr_i  = '0;
        s_wvalid_i  = 1'b0;
        s_wdata_i   = '0;
        s_wstrb_i   = '0;
        s_bready_i  = 1'b0;
        s_arvalid_i = 1'b0;
        s_araddr_i  = '0;
        s_rready_i  = 1'b0;
        irq_src_i   = '0;
        repeat (2) @(posedge clk);
        rst_i <= 1'b0;

        // timer counts and fires at mtimecmp
        axil_read(reg_addr(`PLAT_RTC_REGION, `MTIME_LO), t0, resp);
        axil_read(reg_addr(`PLAT_RTC_REGION, `MTIME_LO), t1, resp);
        assert (t1 > t0) else
            abort_run($sformatf("FAILED at %0d ns: mtime went from %0d to %0d", $time, t0, t1));
        write_check(reg_addr(`PLAT_RTC_REGION, `MTIMECMP_HI), 32'h0, OKAY);
        cmp_off = $urandom_range(40, 20);
        axil_read(reg_addr(`PLAT_RTC_REGION, `MTIME_LO), t0, resp);
        write_check(reg_addr(`PLAT_RTC_REGION, `MTIMECMP_LO), t0 + cmp_off, OKAY);
        @(negedge clk);
        irq_check(`PLAT_MTI_BIT, 1'b0);
        wait_irq(`PLAT_MTI_BIT, 1'b1, int'(cmp_off) + 10);
        write_check(reg_addr(`PLAT_RTC_REGION, `MTIMECMP_LO), 32'hFFFF_FFFF, OKAY);
        write_check(reg_addr(`PLAT_RTC_REGION, `MTIMECMP_HI), 32'hFFFF_FFFF, OKAY);
        @(negedge clk);
        irq_check(`PLAT_MTI_BIT, 1'b0);

        // sources 2 and 3 with the lowest id claimed first
        @(posedge clk);
        irq_src_i <= 4'b0110;
        write_check(reg_addr(`PLAT_PLIC_LO, `PLIC_ENABLE), 32'hF, OKAY);
        wait_irq(`PLAT_MEI_BIT, 1'b1, 20);
        read_check(reg_addr(`PLAT_PLIC_LO, `PLIC_CLAIM), 32'd2, OKAY);
        @(negedge clk);
        irq_check(`PLAT_MEI_BIT, 1'b1);  // source 3 still waiting
        read_check(reg_addr(`PLAT_PLIC_LO, `PLIC_CLAIM), 32'd3, OKAY);
        @(negedge clk);
        irq_check(`PLAT_MEI_BIT, 1'b0);  // both in service
        read_check(reg_addr(`PLAT_PLIC_LO, `PLIC_CLAIM), 32'd0, OKAY);

        // complete re-arms source 2
        write_check(reg_addr(`PLAT_PLIC_LO, `PLIC_CLAIM), 32'd2, OKAY);
        read_check(reg_addr(`PLAT_PLIC_LO, `PLIC_PENDING), 32'h2, OKAY);
        wait_irq(`PLAT_MEI_BIT, 1'b1, 20);

        // masked sources stay quiet
        @(posedge clk);
        irq_src_i <= 4'b0111;
        write_check(reg_addr(`PLAT_PLIC_LO, `PLIC_ENABLE), 32'h0, OKAY);
        wait_irq(`PLAT_MEI_BIT, 1'b0, 10);
        repeat (10) begin
            @(negedge clk);
            irq_check(`PLAT_MEI_BIT, 1'b0);
        end
        read_check(reg_addr(`PLAT_PLIC_LO, `PLIC_PENDING), 32'h3, OKAY);

        // unmapped regions
        read_check(reg_addr(4'h0, 4'h4), 32'h0, SLVERR);
        read_check(reg_addr(4'h9, 4'h8), 32'h0, SLVERR);
        write_check(reg_addr(4'h0, `MTIMECMP_HI), 32'h1234_5678, SLVERR);
        write_check(reg_addr(4'h9, `PLIC_ENABLE), 32'hFFFF_FFFF, SLVERR);
        read_check(reg_addr(`PLAT_RTC_REGION, `MTIMECMP_HI), 32'hFFFF_FFFF, OKAY);
        read_check(reg_addr(`PLAT_PLIC_LO, `PLIC_ENABLE), 32'h0, OKAY);

        if (i_dut.i_chk.err_cnt == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("Verification failed");
            $fatal(1, "checker reported errors");
        end
    end

endmodule

`default_nettype wire

// ==== src/mmio_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "plat_consts.svh"

module mmio_decoder
    import plat_pkg::*;
(
    input  logic       clk,
    input  logic       rst_i,
    // write address / data
    input  logic       s_awvalid_i,
    input  word_t      s_awaddr_i,
    input  logic       s_wvalid_i,
    input  word_t      s_wdata_i,
    input  strb_t      s_wstrb_i,
    output logic       s_awready_o,
    output logic       s_wready_o,
    output logic       s_bvalid_o,
    output logic [1:0] s_bresp_o,
    input  logic       s_bready_i,
    // read address / data
    input  logic       s_arvalid_i,
    input  word_t      s_araddr_i,
    output logic       s_arready_o,
    output logic       s_rvalid_o,
    output word_t      s_rdata_o,
    output logic [1:0] s_rresp_o,
    input  logic       s_rready_i,
    // block side
    output mmio_req_t  req_o,
    output logic       rtc_sel_o,
    output logic       plic_sel_o,
    input  word_t      rtc_rdata_i,
    input  word_t      plic_rdata_i
);

    dec_state_t state_q, state_d;
    logic       idle;
    logic       wr_both;
    logic       wr_acc, rd_acc;
    word_t      addr;
    logic [3:0] nib;
    logic       rtc_hit, plic_hit;
    logic [1:0] resp_q;
    word_t      rdata_q;

    ////////////////////
    // accept
    ////////////////////

    assign idle    = (state_q == DEC_IDLE);
    assign wr_both = s_awvalid_i & s_wvalid_i;

    assign s_awready_o = idle;
    assign s_wready_o  = idle;
    assign s_arready_o = idle & ~wr_both;  // write wins a tie

    assign wr_acc = idle & wr_both;
    assign rd_acc = idle & s_arvalid_i & ~wr_both;

    assign addr     = wr_acc ? s_awaddr_i : s_araddr_i;
    assign nib      = addr[31:28];
    assign rtc_hit  = (nib == `PLAT_RTC_REGION);
    assign plic_hit = (nib >= `PLAT_PLIC_LO) && (nib <= `PLAT_PLIC_HI);

    // shared request, only meaningful together with a select
    assign req_o.we    = wr_acc;
    assign req_o.re    = rd_acc;
    assign req_o.off   = addr[3:0];
    assign req_o.wdata = s_wdata_i;
    assign req_o.strb  = s_wstrb_i;

    assign rtc_sel_o  = (wr_acc | rd_acc) & rtc_hit;
    assign plic_sel_o = (wr_acc | rd_acc) & plic_hit;

    ////////////////////
    // fsm
    ////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            DEC_IDLE: begin
                if (wr_acc) begin
                    state_d = DEC_WRESP;
                end else if (rd_acc) begin
                    state_d = DEC_RRESP;
                end
            end
            DEC_WRESP: if (s_bready_i) state_d = DEC_IDLE;
            DEC_RRESP: if (s_rready_i) state_d = DEC_IDLE;
            default:   state_d = DEC_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= DEC_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // response payload, captured in the accept cycle
    always_ff @(posedge clk) begin
        if (wr_acc | rd_acc) begin
            resp_q <= (rtc_hit | plic_hit) ? 2'b00 : 2'b10;  // OKAY / SLVERR
        end
        if (rd_acc) begin
            if (rtc_hit) begin
                rdata_q <= rtc_rdata_i;
            end else if (plic_hit) begin
                rdata_q <= plic_rdata_i;
            end else begin
                rdata_q <= '0;  // unmapped reads as zero
            end
        end
    end

    assign s_bvalid_o = (state_q == DEC_WRESP);
    assign s_rvalid_o = (state_q == DEC_RRESP);
    assign s_bresp_o  = resp_q;
    assign s_rresp_o  = resp_q;
    assign s_rdata_o  = rdata_q;

endmodule

`default_nettype wire

// ==== src/mtimer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "plat_consts.svh"

module mtimer
    import plat_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,
    input  logic      sel_i,
    input  mmio_req_t req_i,
    output word_t     rdata_o,
    output logic      mti_o
);

    mtime_t   mtime_q;
    mtime_t   mtimecmp_q;
    logic     mti_q;
    logic     wr;
    reg_off_t off;

    assign wr  = sel_i & req_i.we;
    assign off = req_i.off;

    // mtime, a write replaces this cycle's tick
    always_ff @(posedge clk) begin
        if (rst_i) begin
            mtime_q <= '0;
        end else if (wr && off == `MTIME_LO) begin
            mtime_q <= {mtime_q[63:32], apply_strb(mtime_q[31:0], req_i.wdata, req_i.strb)};
        end else if (wr && off == `MTIME_HI) begin
            mtime_q <= {apply_strb(mtime_q[63:32], req_i.wdata, req_i.strb), mtime_q[31:0]};
        end else begin
            mtime_q <= mtime_q + 64'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mtimecmp_q <= `MTIMECMP_RST;
        end else if (wr && off == `MTIMECMP_LO) begin
            mtimecmp_q[31:0] <= apply_strb(mtimecmp_q[31:0], req_i.wdata, req_i.strb);
        end else if (wr && off == `MTIMECMP_HI) begin
            mtimecmp_q[63:32] <= apply_strb(mtimecmp_q[63:32], req_i.wdata, req_i.strb);
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mti_q <= 1'b0;
        end else begin
            mti_q <= (mtime_q >= mtimecmp_q);  // one cycle behind the compare
        end
    end

    always_comb begin
        case (off)
            `MTIME_LO:    rdata_o = mtime_q[31:0];
            `MTIME_HI:    rdata_o = mtime_q[63:32];
            `MTIMECMP_LO: rdata_o = mtimecmp_q[31:0];
            `MTIMECMP_HI: rdata_o = mtimecmp_q[63:32];
            default:      rdata_o = '0;
        endcase
    end

    assign mti_o = mti_q;

endmodule

`default_nettype wire

// ==== src/plat_consts.svh ====
`ifndef PLAT_CONSTS_SVH
`define PLAT_CONSTS_SVH

// region nibbles, taken from addr[31:28]
`define PLAT_RTC_REGION  4'h2
`define PLAT_PLIC_LO     4'h3
`define PLAT_PLIC_HI     4'h7

`define PLAT_SRC_CNT     4   // external interrupt sources

// timer register offsets
`define MTIME_LO         4'h0
`define MTIME_HI         4'h4
`define MTIMECMP_LO      4'h8
`define MTIMECMP_HI      4'hC

// interrupt controller offsets
`define PLIC_PENDING     4'h0
`define PLIC_ENABLE      4'h4
`define PLIC_CLAIM       4'h8

`define MTIMECMP_RST     64'hFFFF_FFFF_FFFF_FFFF  // keeps mti low out of reset

`define PLAT_MTI_BIT     7
`define PLAT_MEI_BIT     11

`endif

// ==== src/plat_pkg.sv ====
`default_nettype none

`include "plat_consts.svh"

package plat_pkg;

    typedef logic [31:0]              word_t;
    typedef logic [3:0]               strb_t;
    typedef logic [3:0]               reg_off_t;
    typedef logic [63:0]              mtime_t;
    typedef logic [`PLAT_SRC_CNT-1:0] src_mask_t;
    typedef logic [2:0]               src_id_t;   // 0 = no source

    // one access towards a block, valid for a single cycle
    typedef struct packed {
        logic     we;
        logic     re;
        reg_off_t off;
        word_t    wdata;
        strb_t    strb;
    } mmio_req_t;

    typedef enum logic [1:0] {
        DEC_IDLE,
        DEC_WRESP,
        DEC_RRESP
    } dec_state_t;

    // byte lane merge for partial writes
    function automatic word_t apply_strb(word_t old_w, word_t new_w, strb_t strb);
        word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

endpackage

`default_nettype wire

// ==== src/plat_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "plat_consts.svh"

module plat_top
    import plat_pkg::*;
(
    input  logic       clk,
    input  logic       rst_i,
    // axi4-lite slave
    input  logic       s_awvalid_i,
    input  word_t      s_awaddr_i,
    input  logic       s_wvalid_i,
    input  word_t      s_wdata_i,
    input  strb_t      s_wstrb_i,
    output logic       s_awready_o,
    output logic       s_wready_o,
    output logic       s_bvalid_o,
    output logic [1:0] s_bresp_o,
    input  logic       s_bready_i,
    input  logic       s_arvalid_i,
    input  word_t      s_araddr_i,
    output logic       s_arready_o,
    output logic       s_rvalid_o,
    output word_t      s_rdata_o,
    output logic [1:0] s_rresp_o,
    input  logic       s_rready_i,
    // interrupts
    input  src_mask_t  irq_src_i,
    output word_t      irq_o
);

    mmio_req_t req;
    logic      rtc_sel, plic_sel;
    word_t     rtc_rdata, plic_rdata;
    logic      mti, meip;

    ////////////////////
    // bus decode
    ////////////////////

    mmio_decoder i_dec (
        .clk          (clk),
        .rst_i        (rst_i),
        .s_awvalid_i  (s_awvalid_i),
        .s_awaddr_i   (s_awaddr_i),
        .s_wvalid_i   (s_wvalid_i),
        .s_wdata_i    (s_wdata_i),
        .s_wstrb_i    (s_wstrb_i),
        .s_awready_o  (s_awready_o),
        .s_wready_o   (s_wready_o),
        .s_bvalid_o   (s_bvalid_o),
        .s_bresp_o    (s_bresp_o),
        .s_bready_i   (s_bready_i),
        .s_arvalid_i  (s_arvalid_i),
        .s_araddr_i   (s_araddr_i),
        .s_arready_o  (s_arready_o),
        .s_rvalid_o   (s_rvalid_o),
        .s_rdata_o    (s_rdata_o),
        .s_rresp_o    (s_rresp_o),
        .s_rready_i   (s_rready_i),
        .req_o        (req),
        .rtc_sel_o    (rtc_sel),
        .plic_sel_o   (plic_sel),
        .rtc_rdata_i  (rtc_rdata),
        .plic_rdata_i (plic_rdata)
    );

    ////////////////////
    // blocks
    ////////////////////

    mtimer i_rtc (
        .clk     (clk),
        .rst_i   (rst_i),
        .sel_i   (rtc_sel),
        .req_i   (req),
        .rdata_o (rtc_rdata),
        .mti_o   (mti)
    );

    plic_core i_plic (
        .clk       (clk),
        .rst_i     (rst_i),
        .sel_i     (plic_sel),
        .req_i     (req),
        .irq_src_i (irq_src_i),
        .rdata_o   (plic_rdata),
        .meip_o    (meip)
    );

    // mip layout, other bits tied low
    assign irq_o = (word_t'(mti) << `PLAT_MTI_BIT) | (word_t'(meip) << `PLAT_MEI_BIT);

endmodule

`default_nettype wire

// ==== src/plic_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "plat_consts.svh"

module plic_core
    import plat_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,
    input  logic      sel_i,
    input  mmio_req_t req_i,
    input  src_mask_t irq_src_i,
    output word_t     rdata_o,
    output logic      meip_o
);

    src_mask_t pending_q;
    src_mask_t enable_q;
    src_mask_t in_service_q;
    logic      meip_q;

    src_mask_t active;
    src_mask_t claim_oh;
    src_id_t   claim_id;
    logic      claim_rd;
    logic      cmpl_wr;
    src_id_t   cmpl_id;
    src_mask_t cmpl_mask;
    logic      en_wr;

    assign claim_rd = sel_i & req_i.re & (req_i.off == `PLIC_CLAIM);
    assign cmpl_wr  = sel_i & req_i.we & (req_i.off == `PLIC_CLAIM);
    assign en_wr    = sel_i & req_i.we & (req_i.off == `PLIC_ENABLE) & req_i.strb[0];
    assign cmpl_id  = req_i.wdata[2:0];

    ////////////////////
    // claim select
    ////////////////////

    assign active   = pending_q & enable_q;
    assign claim_oh = active & (~active + src_mask_t'(1));  // lowest set bit

    always_comb begin
        claim_id = '0;
        for (int i = `PLAT_SRC_CNT - 1; i >= 0; i--) begin
            if (active[i]) begin
                claim_id = src_id_t'(i + 1);
            end
        end
    end

    // id n completes mask bit n-1
    always_comb begin
        cmpl_mask = '0;
        for (int i = 0; i < `PLAT_SRC_CNT; i++) begin
            if (cmpl_wr && cmpl_id == src_id_t'(i + 1)) begin
                cmpl_mask[i] = 1'b1;
            end
        end
    end

    ////////////////////
    // state
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pending_q    <= '0;
            enable_q     <= '0;
            in_service_q <= '0;
            meip_q       <= 1'b0;
        end else begin
            // gateway: level sets pending unless already in service
            pending_q <= (pending_q | (irq_src_i & ~in_service_q))
                         & ~(claim_rd ? claim_oh : '0);
            in_service_q <= (in_service_q | (claim_rd ? claim_oh : '0)) & ~cmpl_mask;
            if (en_wr) begin
                enable_q <= req_i.wdata[`PLAT_SRC_CNT-1:0];
            end
            meip_q <= |active;
        end
    end

    always_comb begin
        case (req_i.off)
            `PLIC_PENDING: rdata_o = word_t'(pending_q);
            `PLIC_ENABLE:  rdata_o = word_t'(enable_q);
            `PLIC_CLAIM:   rdata_o = word_t'(claim_id);
            default:       rdata_o = '0;
        endcase
    end

    assign meip_o = meip_q;

endmodule

`default_nettype wire
